//--- logic/mdu_pkg.sv
package mdu_pkg;

	localparam int xlen = 64;

	// operand and result word
	typedef logic [xlen-1:0] data_t;

	// bit 0 unsigned, bit 1 remainder wanted
	typedef logic [1:0] div_op_t;

	localparam div_op_t op_div  = 2'b00;
	localparam div_op_t op_divu = 2'b01;
	localparam div_op_t op_rem  = 2'b10;
	localparam div_op_t op_remu = 2'b11;

	localparam int div_steps = 64; // one quotient bit per step

	typedef logic [$clog2(div_steps)-1:0] count_t;

	localparam count_t div_last = count_t'(div_steps - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_done
	} div_state_t;

endpackage

//--- logic/div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep (
	input  logic             clk,
	input  logic             reset,
	input  logic             flush,
	input  logic             div_valid,
	input  mdu_pkg::div_op_t div_op,
	input  logic             div_word,
	input  mdu_pkg::data_t   dividend,
	input  mdu_pkg::data_t   divisor,
	input  logic             core_idle,
	output logic             div_ready,
	output logic             prep_valid,
	output mdu_pkg::data_t   x_abs,
	output mdu_pkg::data_t   y_abs,
	output logic             quot_neg,
	output logic             rem_neg,
	output logic             op_rem,
	output logic             op_word
);

	logic accept;
	logic is_unsigned;
	logic wants_rem;
	logic x_sign;
	logic y_sign;
	logic y_zero;

	// magnitude of a 32 or 64 bit operand, zero-extended for word forms
	function automatic mdu_pkg::data_t magnitude(
		input mdu_pkg::data_t v,
		input logic           word,
		input logic           neg
	);
		mdu_pkg::data_t full;
		mdu_pkg::data_t mag;
		full = word ? {32'b0, v[31:0]} : v;
		mag  = neg ? mdu_pkg::data_t'(-full) : full;
		if (word) begin
			mag = {32'b0, mag[31:0]}; // drop borrow into upper half
		end
		return mag;
	endfunction

	assign is_unsigned = (div_op == mdu_pkg::op_divu) || (div_op == mdu_pkg::op_remu);
	assign wants_rem   = (div_op == mdu_pkg::op_rem) || (div_op == mdu_pkg::op_remu);

	assign x_sign = !is_unsigned && (div_word ? dividend[31] : dividend[mdu_pkg::xlen-1]);
	assign y_sign = !is_unsigned && (div_word ? divisor[31] : divisor[mdu_pkg::xlen-1]);
	assign y_zero = div_word ? (divisor[31:0] == 32'b0) : (divisor == '0);

	assign div_ready = core_idle && !prep_valid; // core not yet loaded
	assign accept    = div_valid && div_ready && !flush;

	always_ff @(posedge clk) begin
		if (reset) begin
			prep_valid <= 1'b0;
		end else begin
			prep_valid <= accept; // one cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			x_abs    <= magnitude(dividend, div_word, x_sign);
			y_abs    <= magnitude(divisor, div_word, y_sign);
			quot_neg <= (x_sign ^ y_sign) && !y_zero; // all ones quotient on /0
			rem_neg  <= x_sign;
			op_rem   <= wants_rem;
			op_word  <= div_word;
		end
	end

endmodule

//--- logic/div_core.sv
`timescale 1ns/1ps

module div_core (
	input  logic           clk,
	input  logic           reset,
	input  logic           flush,
	input  logic           prep_valid,
	input  mdu_pkg::data_t x_abs,
	input  mdu_pkg::data_t y_abs,
	output logic           core_idle,
	output logic           core_done,
	output mdu_pkg::data_t quot_raw,
	output mdu_pkg::data_t rem_raw
);

	mdu_pkg::div_state_t    state;
	mdu_pkg::count_t        step_cnt;
	logic                   steps_over; // every quotient bit formed
	mdu_pkg::data_t         q_work;     // dividend bits out, quotient bits in
	mdu_pkg::data_t         r_work;     // partial remainder
	mdu_pkg::data_t         y_work;
	logic [mdu_pkg::xlen:0] r_shift;
	logic [mdu_pkg::xlen:0] r_diff;
	logic                   fits;
	logic                   load;
	logic                   step;
	logic                   publish;

	// shift in next dividend bit, then trial subtract
	assign r_shift = {r_work, q_work[mdu_pkg::xlen-1]};
	assign r_diff  = r_shift - {1'b0, y_work};
	assign fits    = ~r_diff[mdu_pkg::xlen]; // no borrow

	assign load    = (state == mdu_pkg::st_idle) && prep_valid;
	assign step    = (state == mdu_pkg::st_busy) && !steps_over;
	assign publish = (state == mdu_pkg::st_busy) && steps_over;

	assign core_idle = (state == mdu_pkg::st_idle);
	assign core_done = (state == mdu_pkg::st_done);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			state      <= mdu_pkg::st_idle;
			step_cnt   <= '0;
			steps_over <= 1'b0;
		end else begin
			case (state)
				mdu_pkg::st_idle: begin
					if (prep_valid) begin
						state      <= mdu_pkg::st_busy;
						step_cnt   <= '0;
						steps_over <= 1'b0;
					end
				end
				mdu_pkg::st_busy: begin
					if (steps_over) begin
						state <= mdu_pkg::st_done;
					end else begin
						step_cnt   <= step_cnt + 1'b1;
						steps_over <= (step_cnt == mdu_pkg::div_last);
					end
				end
				mdu_pkg::st_done: begin
					state <= mdu_pkg::st_idle; // done lasts one cycle
				end
				default: begin
					state <= mdu_pkg::st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			q_work <= x_abs;
			r_work <= '0;
			y_work <= y_abs;
		end else if (step) begin
			q_work <= {q_work[mdu_pkg::xlen-2:0], fits};
			r_work <= fits ? r_diff[mdu_pkg::xlen-1:0] : r_shift[mdu_pkg::xlen-1:0];
		end
	end

	// result stays put while fix samples it
	always_ff @(posedge clk) begin
		if (publish) begin
			quot_raw <= q_work;
			rem_raw  <= r_work;
		end
	end

endmodule

//--- logic/div_result_fix.sv
`timescale 1ns/1ps

module div_result_fix (
	input  logic           clk,
	input  logic           reset,
	input  logic           flush,
	input  logic           core_done,
	input  mdu_pkg::data_t quot_raw,
	input  mdu_pkg::data_t rem_raw,
	input  logic           quot_neg,
	input  logic           rem_neg,
	input  logic           op_rem,
	input  logic           op_word,
	output logic           out_valid,
	output mdu_pkg::data_t result
);

	mdu_pkg::data_t quot_s;
	mdu_pkg::data_t rem_s;
	mdu_pkg::data_t pick;
	mdu_pkg::data_t fixed;
	logic           take;

	assign quot_s = quot_neg ? mdu_pkg::data_t'(-quot_raw) : quot_raw;
	assign rem_s  = rem_neg ? mdu_pkg::data_t'(-rem_raw) : rem_raw; // sign of dividend
	assign pick   = op_rem ? rem_s : quot_s;

	// word forms sign-extend bit 31
	assign fixed = op_word ? {{32{pick[31]}}, pick[31:0]} : pick;

	assign take = core_done && !flush;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			result    <= '0;
		end else begin
			out_valid <= take;
			if (take) begin
				result <= fixed; // held until next result
			end
		end
	end

endmodule

//--- logic/div_unit.sv
`timescale 1ns/1ps

module div_unit (
	input  logic             clk,
	input  logic             reset,
	input  logic             flush,
	input  logic             div_valid,
	input  mdu_pkg::div_op_t div_op,
	input  logic             div_word,
	input  mdu_pkg::data_t   dividend,
	input  mdu_pkg::data_t   divisor,
	output logic             div_ready,
	output logic             out_valid,
	output mdu_pkg::data_t   result
);

	logic           prep_valid;
	mdu_pkg::data_t x_abs;
	mdu_pkg::data_t y_abs;
	logic           quot_neg;
	logic           rem_neg;
	logic           op_rem;
	logic           op_word;
	logic           core_idle;
	logic           core_done;
	mdu_pkg::data_t quot_raw;
	mdu_pkg::data_t rem_raw;

	div_operand_prep i_prep (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.div_valid  (div_valid),
		.div_op     (div_op),
		.div_word   (div_word),
		.dividend   (dividend),
		.divisor    (divisor),
		.core_idle  (core_idle),
		.div_ready  (div_ready),
		.prep_valid (prep_valid),
		.x_abs      (x_abs),
		.y_abs      (y_abs),
		.quot_neg   (quot_neg),
		.rem_neg    (rem_neg),
		.op_rem     (op_rem),
		.op_word    (op_word)
	);

	div_core i_core (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.prep_valid (prep_valid),
		.x_abs      (x_abs),
		.y_abs      (y_abs),
		.core_idle  (core_idle),
		.core_done  (core_done),
		.quot_raw   (quot_raw),
		.rem_raw    (rem_raw)
	);

	// signs and op come straight from prep, held for the whole run
	div_result_fix i_fix (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.core_done  (core_done),
		.quot_raw   (quot_raw),
		.rem_raw    (rem_raw),
		.quot_neg   (quot_neg),
		.rem_neg    (rem_neg),
		.op_rem     (op_rem),
		.op_word    (op_word),
		.out_valid  (out_valid),
		.result     (result)
	);

endmodule

//--- tb/div_checker.sv
`timescale 1ns/1ps

module div_checker (
	input  logic             clk,
	input  logic             reset,
	input  logic             flush,
	input  logic             div_valid,
	input  mdu_pkg::div_op_t div_op,
	input  logic             div_word,
	input  mdu_pkg::data_t   dividend,
	input  mdu_pkg::data_t   divisor,
	input  logic             div_ready,
	input  logic             out_valid,
	input  mdu_pkg::data_t   result,
	output int               errors,
	output int               checks,
	output int               accepted,
	output logic             pending
);

	localparam int latency = 67; // accepting edge to out_valid edge

	int             cyc = 0;
	int             acc_cyc = 0;
	logic           ready_due = 1'b0;
	mdu_pkg::data_t expected = '0;

	// RISC-V division truncates toward zero and the remainder follows the dividend
	function automatic mdu_pkg::data_t reference_result(
		input mdu_pkg::div_op_t op,
		input logic             word,
		input mdu_pkg::data_t   a,
		input mdu_pkg::data_t   b
	);
		logic           uns;
		logic           want_rem;
		logic [31:0]    a32;
		logic [31:0]    b32;
		logic [31:0]    r32;
		int             wa;
		int             wb;
		longint         sa;
		longint         sb;
		mdu_pkg::data_t r;
		uns      = (op == mdu_pkg::op_divu) || (op == mdu_pkg::op_remu);
		want_rem = (op == mdu_pkg::op_rem) || (op == mdu_pkg::op_remu);
		a32 = a[31:0];
		b32 = b[31:0];
		wa  = int'(a32);
		wb  = int'(b32);
		sa  = longint'(a);
		sb  = longint'(b);
		if (word) begin
			if (b32 == 32'h0) begin
				r32 = want_rem ? a32 : 32'hffff_ffff;
			end else if (!uns && a32 == 32'h8000_0000 && b32 == 32'hffff_ffff) begin
				r32 = want_rem ? 32'h0 : a32; // signed overflow
			end else if (uns) begin
				r32 = want_rem ? a32 % b32 : a32 / b32;
			end else begin
				r32 = want_rem ? wa % wb : wa / wb;
			end
			r = {{32{r32[31]}}, r32};
		end else begin
			if (b == '0) begin
				r = want_rem ? a : '1;
			end else if (!uns && a == {1'b1, 63'b0} && b == '1) begin
				r = want_rem ? '0 : a;
			end else if (uns) begin
				r = want_rem ? a % b : a / b;
			end else begin
				r = want_rem ? sa % sb : sa / sb;
			end
		end
		return r;
	endfunction

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (reset) begin
			errors    = 0;
			checks    = 0;
			accepted  = 0;
			pending   = 1'b0;
			ready_due = 1'b0;
		end else begin
			if (ready_due && !div_ready) begin
				$display("time %0t: div_ready did not return one cycle after a flush", $time);
				errors++;
			end
			ready_due = 1'b0;
			if (out_valid) begin
				if (!pending) begin
					$display("time %0t: out_valid without a pending request", $time);
					errors++;
				end else begin
					checks++;
					if (cyc - 1 - acc_cyc != latency) begin
						$display("CHECK FAILED time %0t signal out_valid latency expected %0d actual %0d",
							$time, latency, cyc - 1 - acc_cyc);
						errors++;
					end
					if (result !== expected) begin
						$display("CHECK FAILED time %0t signal result expected %h actual %h",
							$time, expected, result);
						errors++;
					end
					pending = 1'b0;
				end
			end
			if (pending && cyc > acc_cyc + latency) begin
				$display("time %0t: no out_valid for the request accepted at cycle %0d",
					$time, acc_cyc);
				errors++;
				pending = 1'b0;
			end
			if (pending && div_ready) begin
				$display("CHECK FAILED time %0t signal div_ready expected 0 actual 1", $time);
				errors++;
			end
			if (flush) begin
				pending   = 1'b0; // cancelled so no result may follow
				ready_due = 1'b1;
			end
			if (div_valid && div_ready && !flush) begin
				pending  = 1'b1;
				acc_cyc  = cyc;
				expected = reference_result(div_op, div_word, dividend, divisor);
				accepted++;
			end
		end
	end

endmodule

//--- tb/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb;

	localparam int num_ops = 400;
	localparam int timeout_cycles = num_ops * 75 + 100;

	logic             clk;
	logic             reset;
	logic             flush;
	logic             div_valid;
	mdu_pkg::div_op_t div_op;
	logic             div_word;
	mdu_pkg::data_t   dividend;
	mdu_pkg::data_t   divisor;
	logic             div_ready;
	logic             out_valid;
	mdu_pkg::data_t   result;
	int               errors;
	int               checks;
	int               accepted;
	logic             pending;
	integer           seed;
	int               cycles = 0;

	div_unit i_dut (
		.clk       (clk),
		.reset     (reset),
		.flush     (flush),
		.div_valid (div_valid),
		.div_op    (div_op),
		.div_word  (div_word),
		.dividend  (dividend),
		.divisor   (divisor),
		.div_ready (div_ready),
		.out_valid (out_valid),
		.result    (result)
	);

	div_checker i_check (
		.clk       (clk),
		.reset     (reset),
		.flush     (flush),
		.div_valid (div_valid),
		.div_op    (div_op),
		.div_word  (div_word),
		.dividend  (dividend),
		.divisor   (divisor),
		.div_ready (div_ready),
		.out_valid (out_valid),
		.result    (result),
		.errors    (errors),
		.checks    (checks),
		.accepted  (accepted),
		.pending   (pending)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			if (pending) begin
				$display("a request was left unanswered at the timeout");
			end
			$display("Regression failed");
			$finish;
		end
	end

	// biased toward the corner values of the division rules
	task automatic pick_operand(output mdu_pkg::data_t v);
		logic [31:0] r;
		logic [31:0] junk;
		int          sel;
		r    = $random(seed);
		junk = $random(seed);
		sel  = int'(r[7:0]) % 10;
		case (sel)
			0: v = '0;
			1: v = '1;
			2: v = {1'b1, 63'b0};
			3: v = {60'b0, r[11:8]};
			4: v = '1 - {60'b0, r[11:8]}; // small negative
			5: v = {junk, r[31] ? 32'h8000_0000 : (r[30] ? 32'hffff_ffff : 32'h0)};
			default: v = {junk, r ^ 32'h5a5a_1234};
		endcase
	endtask

	// advance one edge with stray valids while busy
	task automatic next_cycle(input logic stray);
		logic [31:0] r;
		@(posedge clk);
		#1;
		r = $random(seed);
		div_valid = stray & r[0];
	endtask

	task automatic run_request();
		logic [31:0]    r;
		int             gap;
		int             cut;
		mdu_pkg::data_t a;
		mdu_pkg::data_t b;
		r   = $random(seed);
		gap = int'(r[1:0]);
		repeat (gap) next_cycle(1'b0);
		pick_operand(a);
		pick_operand(b);
		r = $random(seed);
		div_op    = r[1:0];
		div_word  = r[2];
		if (r[6:4] == 3'd0) begin
			// signed overflow pair
			a = r[2] ? {a[63:32], 32'h8000_0000} : {1'b1, 63'b0};
			b = r[2] ? {b[63:32], 32'hffff_ffff} : '1;
		end
		dividend  = a;
		divisor   = b;
		div_valid = 1'b1;
		while (!div_ready) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		div_valid = 1'b0;
		dividend  = ~a; // operands are registered at acceptance
		divisor   = b ^ {r, r};
		r = $random(seed);
		if (r % 20 == 0) begin
			cut = int'(r[31:16]) % 67;
			repeat (cut) next_cycle(1'b1);
			div_valid = 1'b0;
			flush     = 1'b1;
			@(posedge clk);
			#1;
			flush = 1'b0;
		end else begin
			while (!out_valid) next_cycle(1'b1);
			div_valid = 1'b0;
		end
	endtask

	initial begin
		seed      = 32'h31ed;
		reset     = 1'b1;
		flush     = 1'b0;
		div_valid = 1'b0;
		div_op    = mdu_pkg::op_div;
		div_word  = 1'b0;
		dividend  = '0;
		divisor   = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int n = 0; n < num_ops; n++) begin
			run_request();
		end
		repeat (4) next_cycle(1'b0);
		$display("errors %0d, results checked %0d, requests accepted %0d",
			errors, checks, accepted);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- build.f
logic/mdu_pkg.sv
logic/div_operand_prep.sv
logic/div_core.sv
logic/div_result_fix.sv
logic/div_unit.sv
tb/div_checker.sv
tb/div_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the divider testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module div_unit_tb -o div_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/div_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1
